/* source/memBusPkg.sv */
// bus types, operation and status codes, address map and request/response structs
package memBusPkg;

	// byte address, cut to 32 bits
	typedef logic [31:0] memAddr;
	// one 64-bit data word
	typedef logic [63:0] memData;
	// operation code
	typedef logic [4:0] memOpm;
	// status code
	typedef logic [1:0] memOk;

	// idle, no request
	localparam memOpm opReady = 5'h00;

	// cache maintenance commands, upper bits zero
	localparam memOpm opLdTlb = 5'h01;
	localparam memOpm opInvTlb = 5'h02;
	localparam memOpm opFlushI = 5'h03;
	localparam memOpm opFlushD = 5'h04;
	localparam memOpm opTrap = 5'h05;

	// memory accesses, low bits all ones
	localparam memOpm opLoad = 5'h0F;
	localparam memOpm opStore = 5'h17;
	// swap has both upper bits set
	localparam memOpm opSwap = 5'h1F;

	localparam memOk okReady = 2'b00;
	localparam memOk okOk = 2'b01;
	localparam memOk okHold = 2'b10;
	localparam memOk okFault = 2'b11;

	// boot ROM
	localparam memAddr romBase = 32'h0000_0000;
	localparam memAddr romLimit = 32'h0000_7FFF;
	// boot SRAM
	localparam memAddr sramBase = 32'h0000_C000;
	localparam memAddr sramLimit = 32'h0000_DFFF;
	// null page, reads zero
	localparam memAddr nullBase = 32'h0001_0000;
	localparam memAddr nullLimit = 32'h000F_FFFF;
	// DRAM window
	localparam memAddr dramBase = 32'h0100_0000;
	localparam memAddr dramLimit = 32'h7FFF_FFFF;
	// register space up to the top of the map
	localparam memAddr mmioBase = 32'hF000_0000;

	// requester to target, 101 bits
	typedef struct packed {
		memAddr addr;
		memOpm opm;
		memData data;
	} memReq;

	// target to requester, 66 bits
	typedef struct packed {
		memData data;
		memOk ok;
	} memResp;

endpackage

/* source/memL2Router.sv */
// second-level router: request register, address decode, command answers, bounce word, watchdog
`timescale 1ns/1ns

module memL2Router #(
	parameter int holdLimit = 255
) (
	input logic clock,
	input logic reset,
	input memBusPkg::memReq cpuReq,
	output memBusPkg::memResp cpuResp,
	output memBusPkg::memReq bootReq,
	output memBusPkg::memReq dramReq,
	output memBusPkg::memReq mmioReq,
	input memBusPkg::memResp bootResp,
	input memBusPkg::memResp dramResp,
	input memBusPkg::memResp mmioResp,
	output memBusPkg::memData bounceIrq,
	output logic deadlock
);

	typedef enum logic [2:0] {
		routeIdle,
		routeCmd,
		routeMmio,
		routeBoot,
		routeDram,
		routeNull,
		routeUnmap
	} routeState;

	// wide enough for holdLimit + 1
	localparam int holdWidth = $clog2(holdLimit + 2);

	memBusPkg::memReq reqQ;
	memBusPkg::memResp respD;
	memBusPkg::memOpm opmD1;
	memBusPkg::memOpm opmD2;
	memBusPkg::memOpm opmD3;
	memBusPkg::memOk cmdOk;
	routeState routeQ;
	routeState decRoute;
	routeState activeRoute;
	logic isAccess;
	logic isSwap;
	logic trapTake;
	logic [holdWidth-1:0] holdCount;

	// input stage, only the opm is control
	always_ff @(posedge clock)
	begin
		reqQ <= cpuReq;
		if (reset)
			reqQ.opm <= memBusPkg::opReady;
	end

	// address map decode of the registered request
	always_comb
	begin
		isAccess = (reqQ.opm == memBusPkg::opLoad) || (reqQ.opm == memBusPkg::opStore) ||
			(reqQ.opm == memBusPkg::opSwap);
		isSwap = reqQ.opm == memBusPkg::opSwap;
		if (reqQ.opm == memBusPkg::opReady)
			decRoute = routeIdle;
		else if (!isAccess)
			decRoute = routeCmd;
		else if (reqQ.addr >= memBusPkg::mmioBase)
			decRoute = routeMmio;
		else if ((reqQ.addr >= memBusPkg::romBase && reqQ.addr <= memBusPkg::romLimit) ||
			(reqQ.addr >= memBusPkg::sramBase && reqQ.addr <= memBusPkg::sramLimit))
			decRoute = routeBoot;
		else if (reqQ.addr >= memBusPkg::dramBase && reqQ.addr <= memBusPkg::dramLimit)
			decRoute = routeDram;
		else if (reqQ.addr >= memBusPkg::nullBase && reqQ.addr <= memBusPkg::nullLimit)
			decRoute = routeNull;
		else
			decRoute = routeUnmap;
		// a latched route wins until its target is back to ready
		activeRoute = (routeQ == routeIdle) ? decRoute : routeQ;
	end

	// commands answered here
	always_comb
	begin
		case (reqQ.opm)
			memBusPkg::opReady:
				cmdOk = memBusPkg::okReady;
			// MMU already saw these
			memBusPkg::opLdTlb, memBusPkg::opInvTlb:
				cmdOk = memBusPkg::okOk;
			// wait until opm is stable for three cycles
			memBusPkg::opFlushI, memBusPkg::opFlushD:
				cmdOk = (reqQ.opm == opmD3) ? memBusPkg::okOk : memBusPkg::okHold;
			memBusPkg::opTrap:
				cmdOk = memBusPkg::okOk;
			// unknown code
			default:
				cmdOk = memBusPkg::okFault;
		endcase
	end

	// response select by route
	always_comb
	begin
		respD = '0;
		case (activeRoute)
			routeCmd:
				respD.ok = cmdOk;
			routeMmio:
				respD = mmioResp;
			routeBoot:
				respD = bootResp;
			routeDram:
				respD = dramResp;
			// zero data, swap faults
			routeNull:
				if (reqQ.opm != memBusPkg::opReady)
					respD.ok = isSwap ? memBusPkg::okFault : memBusPkg::okOk;
			routeUnmap:
				if (reqQ.opm != memBusPkg::opReady)
					respD.ok = memBusPkg::okFault;
			default:
				respD.ok = memBusPkg::okReady;
		endcase
	end

	// live opm only toward the selected target
	assign bootReq = memBusPkg::memReq'{
		addr: reqQ.addr,
		opm: (activeRoute == routeBoot) ? reqQ.opm : memBusPkg::opReady,
		data: reqQ.data
	};
	assign dramReq = memBusPkg::memReq'{
		addr: reqQ.addr,
		opm: (activeRoute == routeDram) ? reqQ.opm : memBusPkg::opReady,
		data: reqQ.data
	};
	assign mmioReq = memBusPkg::memReq'{
		addr: reqQ.addr,
		opm: (activeRoute == routeMmio) ? reqQ.opm : memBusPkg::opReady,
		data: reqQ.data
	};

	// route latch, opm history and response stage
	always_ff @(posedge clock)
	begin
		if (reqQ.opm != memBusPkg::opReady || respD.ok != memBusPkg::okReady)
			routeQ <= activeRoute;
		else
			routeQ <= routeIdle;
		opmD1 <= reqQ.opm;
		opmD2 <= opmD1;
		opmD3 <= opmD2;
		cpuResp <= respD;
		if (reset)
		begin
			routeQ <= routeIdle;
			opmD1 <= memBusPkg::opReady;
			opmD2 <= memBusPkg::opReady;
			opmD3 <= memBusPkg::opReady;
			cpuResp.ok <= memBusPkg::okReady;
		end
	end

	// bit 15 of the latched word blocks further traps
	assign trapTake = (activeRoute == routeCmd) && (reqQ.opm == memBusPkg::opTrap) &&
		!bounceIrq[15];

	always_ff @(posedge clock)
	begin
		if (reset)
			bounceIrq <= '0;
		else if (trapTake)
			bounceIrq <= reqQ.data;
	end

	// consecutive hold cycles, saturating; deadlock is sticky
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			holdCount <= '0;
			deadlock <= 1'b0;
		end
		else
		begin
			if (cpuResp.ok != memBusPkg::okHold)
				holdCount <= '0;
			else if (holdCount <= holdWidth'(holdLimit))
				holdCount <= holdCount + 1'b1;
			if (holdCount > holdWidth'(holdLimit))
				deadlock <= 1'b1;
		end
	end

	// at most one target busy at a time
	oneTargetActive: assert property (@(posedge clock) disable iff (reset)
		$onehot0({bootResp.ok != memBusPkg::okReady, dramResp.ok != memBusPkg::okReady,
			mmioResp.ok != memBusPkg::okReady}));

	// a status other than ready needs a request behind it
	okFromRequest: assert property (@(posedge clock) disable iff (reset)
		(cpuResp.ok == memBusPkg::okReady) ##1 (cpuResp.ok != memBusPkg::okReady)
		|-> ($past(reqQ.opm) != memBusPkg::opReady));

endmodule

/* source/memBootStore.sv */
// boot store: hex-loaded ROM and boot SRAM, answering one cycle after a request
`timescale 1ns/1ns

module memBootStore (
	input logic clock,
	input logic reset,
	input memBusPkg::memReq req,
	output memBusPkg::memResp resp
);

	// 32 ROM words, 64 SRAM words
	memBusPkg::memData rom [0:31];
	memBusPkg::memData sram [0:63];
	logic [4:0] romIndex;
	logic [5:0] sramIndex;
	logic romHit;
	logic sramHit;
	logic isWrite;
	logic firstCycle;
	memBusPkg::memData readWord;

	initial
	begin
		$readmemh("source/bootRom.hex", rom);
	end

	assign romIndex = req.addr[7:3];
	assign sramIndex = req.addr[8:3];
	assign romHit = (req.addr >= memBusPkg::romBase) && (req.addr <= memBusPkg::romLimit);
	assign sramHit = (req.addr >= memBusPkg::sramBase) && (req.addr <= memBusPkg::sramLimit);
	assign isWrite = (req.opm == memBusPkg::opStore) || (req.opm == memBusPkg::opSwap);
	// act once per request
	assign firstCycle = (req.opm != memBusPkg::opReady) && (resp.ok == memBusPkg::okReady);
	// old word, also returned by store and swap
	assign readWord = sramHit ? sram[sramIndex] : rom[romIndex];

	always_ff @(posedge clock)
	begin
		if (reset)
			resp.ok <= memBusPkg::okReady;
		else if (req.opm == memBusPkg::opReady)
			resp.ok <= memBusPkg::okReady;
		else if (firstCycle)
		begin
			resp.ok <= memBusPkg::okOk;
			resp.data <= readWord;
		end
	end

	// ROM writes dropped, still acknowledged
	always_ff @(posedge clock)
	begin
		if (firstCycle && isWrite && sramHit)
			sram[sramIndex] <= req.data;
	end

	// router only selects this store inside its two regions
	inBootRegion: assert property (@(posedge clock) disable iff (reset)
		(req.opm != memBusPkg::opReady) |-> (romHit || sramHit));

endmodule

/* source/memDramStore.sv */
// DRAM stand-in: word store with a fixed hold latency before each answer
`timescale 1ns/1ns

module memDramStore #(
	parameter int dramLatency = 4,
	parameter int dramDepthLog2 = 8
) (
	input logic clock,
	input logic reset,
	input memBusPkg::memReq req,
	output memBusPkg::memResp resp
);

	localparam int depth = 1 << dramDepthLog2;
	// room for the full latency count
	localparam int countWidth = $clog2(dramLatency + 2);

	memBusPkg::memData store [0:depth-1];
	logic [dramDepthLog2-1:0] wordIndex;
	logic [countWidth-1:0] holdCount;
	logic active;
	logic isWrite;
	logic holdDone;
	logic doAccess;

	// address wraps modulo depth
	assign wordIndex = req.addr[dramDepthLog2+2:3];
	assign active = req.opm != memBusPkg::opReady;
	assign isWrite = (req.opm == memBusPkg::opStore) || (req.opm == memBusPkg::opSwap);
	assign holdDone = holdCount == countWidth'(dramLatency);
	// access on the cycle the hold ends
	assign doAccess = active && (resp.ok != memBusPkg::okOk) && holdDone;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			resp.ok <= memBusPkg::okReady;
			holdCount <= '0;
		end
		else if (!active)
		begin
			resp.ok <= memBusPkg::okReady;
			holdCount <= '0;
		end
		else if (resp.ok != memBusPkg::okOk)
		begin
			if (!holdDone)
			begin
				resp.ok <= memBusPkg::okHold;
				holdCount <= holdCount + 1'b1;
			end
			else
			begin
				// old word back for every access
				resp.ok <= memBusPkg::okOk;
				resp.data <= store[wordIndex];
			end
		end
	end

	// array write kept apart for RAM inference
	always_ff @(posedge clock)
	begin
		if (doAccess && isWrite)
			store[wordIndex] <= req.data;
	end

	// requester and router keep the operation steady through the hold
	opmStableInHold: assert property (@(posedge clock) disable iff (reset)
		(resp.ok == memBusPkg::okHold) |-> (req.opm == $past(req.opm)));

endmodule

/* source/memMmioRegs.sv */
// eight scratch registers behind the MMIO window, answering after two hold cycles
`timescale 1ns/1ns

module memMmioRegs (
	input logic clock,
	input logic reset,
	input memBusPkg::memReq req,
	output memBusPkg::memResp resp
);

	localparam logic [1:0] holdCycles = 2'd2;

	memBusPkg::memData scratch [0:7];
	logic [2:0] regIndex;
	logic [1:0] holdCount;
	logic active;
	logic isWrite;

	// word select within the window
	assign regIndex = req.addr[5:3];
	assign active = req.opm != memBusPkg::opReady;
	assign isWrite = (req.opm == memBusPkg::opStore) || (req.opm == memBusPkg::opSwap);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			resp.ok <= memBusPkg::okReady;
			holdCount <= '0;
			scratch <= '{default: '0};
		end
		else if (!active)
		begin
			resp.ok <= memBusPkg::okReady;
			holdCount <= '0;
		end
		else if (resp.ok != memBusPkg::okOk)
		begin
			if (holdCount != holdCycles)
			begin
				resp.ok <= memBusPkg::okHold;
				holdCount <= holdCount + 1'b1;
			end
			else
			begin
				// read value, or old value on store and swap
				resp.ok <= memBusPkg::okOk;
				resp.data <= scratch[regIndex];
				if (isWrite)
					scratch[regIndex] <= req.data;
			end
		end
	end

endmodule

/* source/memSubsystem.sv */
// memory subsystem top: router with boot store, DRAM store and MMIO registers
`timescale 1ns/1ns

module memSubsystem #(
	parameter int holdLimit = 255,
	parameter int dramLatency = 4,
	parameter int dramDepthLog2 = 8
) (
	input logic clock,
	input logic reset,
	input memBusPkg::memReq cpuReq,
	output memBusPkg::memResp cpuResp,
	output memBusPkg::memData bounceIrq,
	output logic deadlock
);

	// router to targets
	memBusPkg::memReq bootReq;
	memBusPkg::memReq dramReq;
	memBusPkg::memReq mmioReq;
	// targets back to router
	memBusPkg::memResp bootResp;
	memBusPkg::memResp dramResp;
	memBusPkg::memResp mmioResp;

	memL2Router #(
		.holdLimit(holdLimit)
	) router_i (
		.clock(clock),
		.reset(reset),
		.cpuReq(cpuReq),
		.cpuResp(cpuResp),
		.bootReq(bootReq),
		.dramReq(dramReq),
		.mmioReq(mmioReq),
		.bootResp(bootResp),
		.dramResp(dramResp),
		.mmioResp(mmioResp),
		.bounceIrq(bounceIrq),
		.deadlock(deadlock)
	);

	memBootStore bootStore_i (
		.clock(clock),
		.reset(reset),
		.req(bootReq),
		.resp(bootResp)
	);

	memDramStore #(
		.dramLatency(dramLatency),
		.dramDepthLog2(dramDepthLog2)
	) dramStore_i (
		.clock(clock),
		.reset(reset),
		.req(dramReq),
		.resp(dramResp)
	);

	memMmioRegs mmioRegs_i (
		.clock(clock),
		.reset(reset),
		.req(mmioReq),
		.resp(mmioResp)
	);

endmodule

/* verif/memSubsystemTb.sv */
// testbench for the memory subsystem: clock, reset, request driver, reference model, checks, timeout
`timescale 1ns/1ns

module memSubsystemTb;

	localparam int holdLimit = 255;
	localparam int dramLatency = 4;
	localparam int dramDepthLog2 = 8;
	localparam int dramWords = 1 << dramDepthLog2;
	localparam int resetCycles = 10;
	localparam int directedCount = 43;
	localparam int randomCount = 120;
	// a DRAM access is the longest round trip
	localparam int cycleLimit =
		(directedCount + randomCount) * (dramLatency + 8) + resetCycles + 40;

	// expected answer of one request
	typedef struct packed {
		memBusPkg::memResp resp;
		logic dataKnown;
		memBusPkg::memData irq;
	} expectEntry;

	logic clock;
	logic reset;
	memBusPkg::memReq cpuReq;
	memBusPkg::memResp cpuResp;
	memBusPkg::memData bounceIrq;
	logic deadlock;

	// reference state
	memBusPkg::memData romImage [0:31];
	memBusPkg::memData sramShadow [0:63];
	logic sramValid [0:63];
	memBusPkg::memData dramShadow [0:dramWords-1];
	logic dramValid [0:dramWords-1];
	memBusPkg::memData mmioShadow [0:7];
	memBusPkg::memData irqModel;

	expectEntry expectQueue [$];
	expectEntry current;
	logic wasDone;
	int errorCount;
	int checkCount;
	int cycleCount;
	int seedValue;

	memSubsystem #(
		.holdLimit(holdLimit),
		.dramLatency(dramLatency),
		.dramDepthLog2(dramDepthLog2)
	) memSubsystem_i (
		.clock(clock),
		.reset(reset),
		.cpuReq(cpuReq),
		.cpuResp(cpuResp),
		.bounceIrq(bounceIrq),
		.deadlock(deadlock)
	);

	// 4 ns period
	always #2 clock = ~clock;

	// run limit
	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout after %0d cycles, a request never completed", cycleCount);
			$display("Errors found");
			$finish;
		end
	end

	task automatic checkData(input string name, input memBusPkg::memData got,
		input memBusPkg::memData expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("ERROR %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic checkOk(input string name, input memBusPkg::memOk got,
		input memBusPkg::memOk expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("ERROR %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic checkIrq(input memBusPkg::memData got, input memBusPkg::memData expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("ERROR bounceIrq: got %h, expected %h", got, expected);
		end
	endtask

	function automatic logic inRange(input memBusPkg::memAddr addr,
		input memBusPkg::memAddr low, input memBusPkg::memAddr high);
		return (addr >= low) && (addr <= high);
	endfunction

	// expected data and status from the address map and shadow stores
	function automatic expectEntry predictResponse(input memBusPkg::memReq req);
		expectEntry e;
		logic isAccess;
		logic isWrite;
		int idx;
		e.resp.data = '0;
		e.resp.ok = memBusPkg::okOk;
		e.dataKnown = 1'b1;
		isWrite = (req.opm == memBusPkg::opStore) || (req.opm == memBusPkg::opSwap);
		isAccess = isWrite || (req.opm == memBusPkg::opLoad);
		if (!isAccess)
		begin
			// commands give zero data, a trap latches unless bit 15 is already set
			if (req.opm == memBusPkg::opTrap && !irqModel[15])
				irqModel = req.data;
		end
		else if (req.addr >= memBusPkg::mmioBase)
		begin
			idx = (req.addr >> 3) % 8;
			e.resp.data = mmioShadow[idx];
			if (isWrite)
				mmioShadow[idx] = req.data;
		end
		else if (inRange(req.addr, memBusPkg::romBase, memBusPkg::romLimit))
		begin
			// writes to ROM vanish, old word still comes back
			idx = ((req.addr - memBusPkg::romBase) >> 3) % 32;
			e.resp.data = romImage[idx];
		end
		else if (inRange(req.addr, memBusPkg::sramBase, memBusPkg::sramLimit))
		begin
			idx = ((req.addr - memBusPkg::sramBase) >> 3) % 64;
			e.resp.data = sramShadow[idx];
			e.dataKnown = sramValid[idx];
			if (isWrite)
			begin
				sramShadow[idx] = req.data;
				sramValid[idx] = 1'b1;
			end
		end
		else if (inRange(req.addr, memBusPkg::dramBase, memBusPkg::dramLimit))
		begin
			// wraps modulo the store depth
			idx = ((req.addr - memBusPkg::dramBase) >> 3) % dramWords;
			e.resp.data = dramShadow[idx];
			e.dataKnown = dramValid[idx];
			if (isWrite)
			begin
				dramShadow[idx] = req.data;
				dramValid[idx] = 1'b1;
			end
		end
		else if (inRange(req.addr, memBusPkg::nullBase, memBusPkg::nullLimit))
		begin
			if (req.opm == memBusPkg::opSwap)
				e.resp.ok = memBusPkg::okFault;
		end
		else
			e.resp.ok = memBusPkg::okFault;
		e.irq = irqModel;
		return e;
	endfunction

	function automatic memBusPkg::memReq makeReq(input memBusPkg::memAddr addr,
		input memBusPkg::memOpm opm, input memBusPkg::memData data);
		memBusPkg::memReq req;
		req.addr = addr;
		req.opm = opm;
		req.data = data;
		return req;
	endfunction

	function automatic memBusPkg::memData randomWord();
		return {$urandom, $urandom};
	endfunction

	// any region, any access, plus TLB and flush commands
	function automatic memBusPkg::memReq randomRequest();
		memBusPkg::memReq req;
		int pick;
		int opPick;
		pick = $urandom % 8;
		opPick = $urandom % 3;
		req.data = randomWord();
		req.opm = (opPick == 0) ? memBusPkg::opLoad :
			(opPick == 1) ? memBusPkg::opStore : memBusPkg::opSwap;
		case (pick)
			0:
				req.addr = memBusPkg::romBase + ($urandom % 32) * 8;
			1:
				req.addr = memBusPkg::sramBase + ($urandom % 64) * 8;
			// a few words, reached through many aliases
			2, 3:
				req.addr = memBusPkg::dramBase +
					(($urandom % 32) + ($urandom % 16) * dramWords) * 8;
			4:
				req.addr = memBusPkg::mmioBase + ($urandom % 8) * 8;
			5:
				req.addr = memBusPkg::nullBase + ($urandom % 32'h1_0000) * 8;
			// gap above the boot SRAM
			6:
				req.addr = 32'h0000_E000 + ($urandom % 32'h200) * 8;
			default:
			begin
				req.addr = '0;
				case ($urandom % 4)
					0: req.opm = memBusPkg::opLdTlb;
					1: req.opm = memBusPkg::opInvTlb;
					2: req.opm = memBusPkg::opFlushI;
					default: req.opm = memBusPkg::opFlushD;
				endcase
			end
		endcase
		return req;
	endfunction

	// one full round trip, back to ready before returning
	task automatic sendRequest(input memBusPkg::memReq req);
		expectQueue.push_back(predictResponse(req));
		@(posedge clock);
		cpuReq <= req;
		@(negedge clock);
		while (cpuResp.ok != memBusPkg::okOk && cpuResp.ok != memBusPkg::okFault)
			@(negedge clock);
		@(posedge clock);
		cpuReq.opm <= memBusPkg::opReady;
		@(negedge clock);
		while (cpuResp.ok != memBusPkg::okReady)
			@(negedge clock);
	endtask

	task automatic romTests();
		for (int i = 0; i < 32; i += 4)
			sendRequest(makeReq(memBusPkg::romBase + i * 8, memBusPkg::opLoad, '0));
		// store must not stick
		sendRequest(makeReq(memBusPkg::romBase + 16, memBusPkg::opStore, 64'hDEAD_BEEF_0BAD_F00D));
		sendRequest(makeReq(memBusPkg::romBase + 16, memBusPkg::opLoad, '0));
	endtask

	task automatic storeLoadTests();
		// boot SRAM, first and last words
		sendRequest(makeReq(memBusPkg::sramBase, memBusPkg::opStore, randomWord()));
		sendRequest(makeReq(memBusPkg::sramBase + 8, memBusPkg::opStore, randomWord()));
		sendRequest(makeReq(memBusPkg::sramBase + 63 * 8, memBusPkg::opStore, randomWord()));
		sendRequest(makeReq(memBusPkg::sramBase, memBusPkg::opLoad, '0));
		sendRequest(makeReq(memBusPkg::sramBase + 8, memBusPkg::opLoad, '0));
		sendRequest(makeReq(memBusPkg::sramBase + 63 * 8, memBusPkg::opLoad, '0));
		sendRequest(makeReq(memBusPkg::sramBase + 8, memBusPkg::opSwap, randomWord()));
		sendRequest(makeReq(memBusPkg::sramBase + 8, memBusPkg::opLoad, '0));
		// DRAM, reads and swaps through wrapped addresses
		sendRequest(makeReq(memBusPkg::dramBase + 3 * 8, memBusPkg::opStore, randomWord()));
		sendRequest(makeReq(memBusPkg::dramBase + (3 + dramWords) * 8, memBusPkg::opLoad, '0));
		sendRequest(makeReq(memBusPkg::dramBase + 200 * 8, memBusPkg::opStore, randomWord()));
		sendRequest(makeReq(memBusPkg::dramBase + (200 + 5 * dramWords) * 8,
			memBusPkg::opSwap, randomWord()));
		sendRequest(makeReq(memBusPkg::dramBase + 200 * 8, memBusPkg::opLoad, '0));
		// MMIO, register 0 still at its reset value
		sendRequest(makeReq(memBusPkg::mmioBase, memBusPkg::opLoad, '0));
		sendRequest(makeReq(memBusPkg::mmioBase + 2 * 8, memBusPkg::opStore, randomWord()));
		sendRequest(makeReq(memBusPkg::mmioBase + 7 * 8, memBusPkg::opStore, randomWord()));
		sendRequest(makeReq(memBusPkg::mmioBase + 2 * 8, memBusPkg::opLoad, '0));
		sendRequest(makeReq(memBusPkg::mmioBase + 7 * 8, memBusPkg::opLoad, '0));
		sendRequest(makeReq(memBusPkg::mmioBase + 7 * 8, memBusPkg::opSwap, randomWord()));
		sendRequest(makeReq(memBusPkg::mmioBase + 7 * 8, memBusPkg::opLoad, '0));
	endtask

	task automatic nullTests();
		sendRequest(makeReq(memBusPkg::nullBase + 32'h40, memBusPkg::opLoad, '0));
		sendRequest(makeReq(memBusPkg::nullBase + 32'h48, memBusPkg::opStore, randomWord()));
		sendRequest(makeReq(memBusPkg::nullBase + 32'h48, memBusPkg::opSwap, randomWord()));
		// holes in the map
		sendRequest(makeReq(32'h0000_8000, memBusPkg::opLoad, '0));
		sendRequest(makeReq(32'h0010_0000, memBusPkg::opStore, randomWord()));
		sendRequest(makeReq(32'h8000_0000, memBusPkg::opSwap, randomWord()));
	endtask

	task automatic commandTests();
		sendRequest(makeReq('0, memBusPkg::opLdTlb, randomWord()));
		sendRequest(makeReq('0, memBusPkg::opInvTlb, randomWord()));
		sendRequest(makeReq('0, memBusPkg::opFlushI, '0));
		sendRequest(makeReq('0, memBusPkg::opFlushD, '0));
	endtask

	task automatic trapTests();
		sendRequest(makeReq('0, memBusPkg::opTrap, 64'h1234_5678_0000_0001));
		// bit 15 set, locks the word
		sendRequest(makeReq('0, memBusPkg::opTrap, 64'hCAFE_0000_0000_8001));
		sendRequest(makeReq('0, memBusPkg::opTrap, 64'hFFFF_1111_2222_3333));
	endtask

	// compares each response once, on its first OK or FAULT cycle
	always @(negedge clock)
	begin
		if (reset)
			wasDone = 1'b0;
		else
		begin
			if ((cpuResp.ok == memBusPkg::okOk || cpuResp.ok == memBusPkg::okFault) && !wasDone)
			begin
				if (expectQueue.size() == 0)
				begin
					errorCount++;
					$display("a response arrived with no request outstanding");
				end
				else
				begin
					current = expectQueue.pop_front();
					checkOk("cpuResp.ok", cpuResp.ok, current.resp.ok);
					if (current.dataKnown)
						checkData("cpuResp.data", cpuResp.data, current.resp.data);
					checkIrq(bounceIrq, current.irq);
					if (deadlock !== 1'b0)
					begin
						errorCount++;
						$display("deadlock flag raised although every hold was short");
					end
				end
			end
			wasDone = (cpuResp.ok == memBusPkg::okOk) || (cpuResp.ok == memBusPkg::okFault);
		end
	end

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		cpuReq = '0;
		errorCount = 0;
		checkCount = 0;
		cycleCount = 0;
		wasDone = 1'b0;
		irqModel = '0;
		seedValue = $urandom(32'h304d);
		$readmemh("source/bootRom.hex", romImage);
		for (int i = 0; i < 64; i++)
			sramValid[i] = 1'b0;
		for (int i = 0; i < dramWords; i++)
			dramValid[i] = 1'b0;
		for (int i = 0; i < 8; i++)
			mmioShadow[i] = '0;
		repeat (resetCycles) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		// idle outputs after reset
		checkOk("cpuResp.ok", cpuResp.ok, memBusPkg::okReady);
		checkIrq(bounceIrq, '0);
		if (deadlock !== 1'b0)
		begin
			errorCount++;
			$display("deadlock flag set right after reset");
		end
		romTests();
		storeLoadTests();
		nullTests();
		commandTests();
		trapTests();
		repeat (randomCount) sendRequest(randomRequest());
		repeat (4) @(negedge clock);
		if (expectQueue.size() != 0)
		begin
			errorCount++;
			$display("%0d requests never got a response", expectQueue.size());
		end
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* source/bootRom.hex */
// one 64-bit boot ROM word per line, hex, word 0 first
B00700A5C0DEFF5A
B00701A5C0DEFE5A
B00702A5C0DEFD5A
B00703A5C0DEFC5A
B00704A5C0DEFB5A
B00705A5C0DEFA5A
B00706A5C0DEF95A
B00707A5C0DEF85A
B00708A5C0DEF75A
B00709A5C0DEF65A
B0070AA5C0DEF55A
B0070BA5C0DEF45A
B0070CA5C0DEF35A
B0070DA5C0DEF25A
B0070EA5C0DEF15A
B0070FA5C0DEF05A
B00710A5C0DEEF5A
B00711A5C0DEEE5A
B00712A5C0DEED5A
B00713A5C0DEEC5A
B00714A5C0DEEB5A
B00715A5C0DEEA5A
B00716A5C0DEE95A
B00717A5C0DEE85A
B00718A5C0DEE75A
B00719A5C0DEE65A
B0071AA5C0DEE55A
B0071BA5C0DEE45A
B0071CA5C0DEE35A
B0071DA5C0DEE25A
B0071EA5C0DEE15A
B0071FA5C0DEE05A

/* src.f */
source/memBusPkg.sv
source/memL2Router.sv
source/memBootStore.sv
source/memDramStore.sv
source/memMmioRegs.sv
source/memSubsystem.sv
verif/memSubsystemTb.sv
